//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_sensor_emu_ctl
FILELIST  = src.f
OBJDIR    = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf $(OBJDIR)

//--- common/emu_consts.svh
// Register map, field bits, widths, FIFO depth, reset defaults and version
`ifndef EMU_CONSTS_SVH
`define EMU_CONSTS_SVH

//==================================================
// Widths and sizes
//==================================================
`define EMU_DATA_W          32
`define EMU_INDEX_W         5
`define EMU_FIFO_DEPTH      16
`define EMU_LEN_W           5

// Bump whenever the register map changes
`define EMU_VERSION         1

// Reset values of the frame generator settings
`define EMU_DEFAULT_CYCLES  32'h0001_0000
`define EMU_DEFAULT_IDLE0   8'hAA
`define EMU_DEFAULT_IDLE1   8'hBB

// Driven on the stream while no FIFO is selected
`define EMU_IDLE_FILL       8'h55

//==================================================
// Register indices
//==================================================
`define EMU_REG_VERSION     0
`define EMU_REG_FIFO_CTL    1
`define EMU_REG_LOAD_F0     2
`define EMU_REG_LOAD_F1     3
`define EMU_REG_START       4
`define EMU_REG_CYCLES      5
`define EMU_REG_IDLE        6

// FIFO_CTL clear bits
`define EMU_BIT_CLR_F0      0
`define EMU_BIT_CLR_F1      1

`endif

//--- common/emu_pkg.sv
// Shared enums and packed structs for the sensor emulator pattern controller
`include "emu_consts.svh"

package emu_pkg;

   //==================================================
   // Enumerations
   //==================================================

   // Names one of the two pattern FIFOs, or none
   typedef enum logic [1:0] {
      SEL_NONE = 2'd0,
      SEL_F0   = 2'd1,
      SEL_F1   = 2'd2
   } fifo_sel_t;

   // Output engine states
   typedef enum logic {
      ST_IDLE = 1'b0,
      ST_RUN  = 1'b1
   } stream_state_t;

   //==================================================
   // Register port
   //==================================================

   // One strobe per access, no handshake
   typedef struct packed {
      logic                    write;
      logic                    read;
      logic [`EMU_INDEX_W-1:0] index;
      logic [`EMU_DATA_W-1:0]  data;
   } reg_req_t;

   // Valid pulses exactly one cycle after the strobe
   typedef struct packed {
      logic                   valid;
      logic                   err;
      logic [`EMU_DATA_W-1:0] data;
   } reg_rsp_t;

   // Settings handed to the frame generator
   typedef struct packed {
      logic [31:0] cycles;
      logic [7:0]  idle0;
      logic [7:0]  idle1;
   } emu_cfg_t;

endpackage

//--- pattern_fifo/pattern_fifo.sv
// Register-array FIFO holding one repeating pattern, with single cycle clear
`timescale 1ns/1ps
`include "emu_consts.svh"

module pattern_fifo #(
   parameter int DEPTH = `EMU_FIFO_DEPTH
) (
   input  logic                   clk,
   input  logic                   resetn,
   input  logic                   clear,
   input  logic                   push,
   input  logic [`EMU_DATA_W-1:0] push_data,
   input  logic                   pop,
   output logic [`EMU_DATA_W-1:0] head,
   output logic                   empty
);

   localparam int PTR_W = $clog2(DEPTH);

   // Storage, no reset needed
   logic [`EMU_DATA_W-1:0] mem [DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   // One extra bit so that a full FIFO is representable
   logic [PTR_W:0]   count;
   logic             full;

   assign empty = (count == '0);
   assign full  = (count == DEPTH[PTR_W:0]);

   // Head word is visible without a read cycle
   assign head = mem[rd_ptr];

   //==================================================
   // Pointers and occupancy
   //==================================================
   always_ff @(posedge clk) begin
      if (!resetn || clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         // Simultaneous push and pop leaves count alone
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;
         endcase
      end
   end

   // Write port
   always_ff @(posedge clk) begin
      if (push) mem[wr_ptr] <= push_data;
   end

   //==================================================
   // Checks
   //==================================================
   // Stream engine pops only on a valid beat
   a_no_underflow: assert property (@(posedge clk) disable iff (!resetn || clear)
      pop |-> !empty);

   // Register lengths keep loads plus recirculation within depth
   a_no_overflow: assert property (@(posedge clk) disable iff (!resetn || clear)
      push |-> !full);

endmodule

//--- src.f
+incdir+common
common/emu_pkg.sv
pattern_fifo/pattern_fifo.sv
src/emu_regs.sv
src/pattern_stream.sv
src/sensor_emu_ctl.sv
testbench/tb_sensor_emu_ctl.sv

//--- src/emu_regs.sv
// Register block: access decode, configuration, pattern lengths, load and clear strobes
`timescale 1ns/1ps
`include "emu_consts.svh"

module emu_regs (
   input  logic                    clk,
   input  logic                    resetn,
   input  emu_pkg::reg_req_t       req,
   output emu_pkg::reg_rsp_t       rsp,
   input  emu_pkg::fifo_sel_t      active,
   output logic [1:0]              load_strobe,
   output logic [`EMU_DATA_W-1:0]  load_data,
   output logic [1:0]              clear,
   output emu_pkg::fifo_sel_t      on_deck,
   output logic [`EMU_LEN_W-1:0]   len0,
   output logic [`EMU_LEN_W-1:0]   len1,
   output emu_pkg::emu_cfg_t       cfg
);
   import emu_pkg::*;

   // A FIFO is off limits once it streams or is about to
   logic busy0;
   logic busy1;
   logic idx_ok;
   logic [`EMU_DATA_W-1:0] rd_data;

   assign busy0 = (active == SEL_F0) || (on_deck == SEL_F0);
   assign busy1 = (active == SEL_F1) || (on_deck == SEL_F1);

   // Indices 0 to 6 exist, everything above is a decode error
   assign idx_ok = (req.index <= `EMU_REG_IDLE);

   //==================================================
   // Write side
   //==================================================
   always_ff @(posedge clk) begin
      // Strobes are single cycle pulses
      load_strobe <= 2'b00;
      clear       <= 2'b00;
      if (!resetn) begin
         len0       <= '0;
         len1       <= '0;
         on_deck    <= SEL_NONE;
         cfg.cycles <= `EMU_DEFAULT_CYCLES;
         cfg.idle0  <= `EMU_DEFAULT_IDLE0;
         cfg.idle1  <= `EMU_DEFAULT_IDLE1;
      end else if (req.write) begin
         case (req.index)
            `EMU_REG_FIFO_CTL: begin
               // Clear zeroes the length now, the FIFO empties next edge
               if (req.data[`EMU_BIT_CLR_F0] && !busy0) begin
                  len0     <= '0;
                  clear[0] <= 1'b1;
               end
               if (req.data[`EMU_BIT_CLR_F1] && !busy1) begin
                  len1     <= '0;
                  clear[1] <= 1'b1;
               end
            end
            // Immediate loads, refused when streaming or full
            `EMU_REG_LOAD_F0: begin
               if (!busy0 && (len0 < `EMU_FIFO_DEPTH)) begin
                  load_strobe <= 2'b01;
                  len0        <= len0 + 1'b1;
               end
            end
            `EMU_REG_LOAD_F1: begin
               if (!busy1 && (len1 < `EMU_FIFO_DEPTH)) begin
                  load_strobe <= 2'b10;
                  len1        <= len1 + 1'b1;
               end
            end
            `EMU_REG_START: begin
               // An empty FIFO can not go on deck
               case (req.data)
                  0: on_deck <= SEL_NONE;
                  1: if (len0 != '0) on_deck <= SEL_F0;
                  2: if (len1 != '0) on_deck <= SEL_F1;
                  default: ;
               endcase
            end
            // Frame settings are frozen while streaming
            `EMU_REG_CYCLES: begin
               if ((req.data != '0) && (active == SEL_NONE)) cfg.cycles <= req.data;
            end
            `EMU_REG_IDLE: begin
               if (active == SEL_NONE) begin
                  cfg.idle0 <= req.data[15:8];
                  cfg.idle1 <= req.data[7:0];
               end
            end
            default: ;
         endcase
      end
   end

   // Word for the push register at the top
   always_ff @(posedge clk) begin
      if (req.write) load_data <= req.data;
   end

   //==================================================
   // Read side and response
   //==================================================
   always_comb begin
      case (req.index)
         `EMU_REG_VERSION: rd_data = `EMU_DATA_W'(`EMU_VERSION);
         `EMU_REG_LOAD_F0: rd_data = `EMU_DATA_W'(len0);
         `EMU_REG_LOAD_F1: rd_data = `EMU_DATA_W'(len1);
         `EMU_REG_START:   rd_data = {30'd0, active};
         `EMU_REG_CYCLES:  rd_data = cfg.cycles;
         `EMU_REG_IDLE:    rd_data = {16'd0, cfg.idle0, cfg.idle1};
         // FIFO_CTL and unknown indices read as zero
         default:          rd_data = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         rsp.valid <= 1'b0;
         rsp.err   <= 1'b0;
      end else begin
         rsp.valid <= req.write | req.read;
         rsp.err   <= (req.write | req.read) && !idx_ok;
      end
   end

   always_ff @(posedge clk) begin
      rsp.data <= req.read ? rd_data : '0;
   end

   //==================================================
   // Checks
   //==================================================
   // Only one FIFO is loaded per access
   a_one_load: assert property (@(posedge clk) disable iff (!resetn)
      load_strobe != 2'b11);

   // Loads never land in the FIFO that the stream engine is recirculating
   a_no_load_active: assert property (@(posedge clk) disable iff (!resetn)
      (load_strobe[0] |-> active != SEL_F0) and (load_strobe[1] |-> active != SEL_F1));

endmodule

//--- src/pattern_stream.sv
// Output FSM: active FIFO selection, per-pass beat count, stream drive and pops
`timescale 1ns/1ps
`include "emu_consts.svh"

module pattern_stream (
   input  logic                   clk,
   input  logic                   resetn,
   input  emu_pkg::fifo_sel_t     on_deck,
   input  logic [`EMU_LEN_W-1:0]  len0,
   input  logic [`EMU_LEN_W-1:0]  len1,
   input  logic [`EMU_DATA_W-1:0] head0,
   input  logic [`EMU_DATA_W-1:0] head1,
   input  logic                   empty0,
   input  logic                   empty1,
   output logic [1:0]             pop,
   output emu_pkg::fifo_sel_t     active,
   output logic [`EMU_DATA_W-1:0] out_tdata,
   output logic                   out_tvalid,
   input  logic                   out_tready
);
   import emu_pkg::*;

   stream_state_t         state;
   logic [`EMU_LEN_W-1:0] beats_left;
   logic [`EMU_LEN_W-1:0] deck_len;
   logic                  act_empty;
   logic                  beat;

   // Length of whatever FIFO is on deck
   assign deck_len = (on_deck == SEL_F0) ? len0 :
                     (on_deck == SEL_F1) ? len1 : '0;

   assign act_empty = (active == SEL_F0) ? empty0 :
                      (active == SEL_F1) ? empty1 : 1'b1;

   //==================================================
   // Stream side
   //==================================================
   // Valid can drop for a cycle while a one word pattern recirculates
   assign out_tvalid = (state == ST_RUN) && !act_empty;
   assign beat       = out_tvalid && out_tready;

   assign out_tdata = (active == SEL_F0) ? head0 :
                      (active == SEL_F1) ? head1 : `EMU_DATA_W'(`EMU_IDLE_FILL);

   // Pop the active FIFO on every handshake
   assign pop = {beat && (active == SEL_F1), beat && (active == SEL_F0)};

   //==================================================
   // FSM
   //==================================================
   always_ff @(posedge clk) begin
      if (!resetn) begin
         state      <= ST_IDLE;
         active     <= SEL_NONE;
         beats_left <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (on_deck != SEL_NONE) begin
                  active     <= on_deck;
                  beats_left <= deck_len;
                  state      <= ST_RUN;
               end
            end
            ST_RUN: begin
               if (beat) begin
                  if (beats_left <= 1) begin
                     // Pass boundary, pick up the next selection
                     if (on_deck == SEL_NONE) begin
                        active <= SEL_NONE;
                        state  <= ST_IDLE;
                     end else begin
                        active     <= on_deck;
                        beats_left <= deck_len;
                     end
                  end else begin
                     beats_left <= beats_left - 1'b1;
                  end
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Stalled beat keeps its word until accepted
   a_hold_data: assert property (@(posedge clk) disable iff (!resetn)
      (out_tvalid && !out_tready) |=> (out_tvalid && $stable(out_tdata)));

endmodule

//--- src/sensor_emu_ctl.sv
// Top level: register block, two pattern FIFOs, stream engine and write-back path
`timescale 1ns/1ps
`include "emu_consts.svh"

module sensor_emu_ctl (
   input  logic                   clk,
   input  logic                   resetn,
   input  emu_pkg::reg_req_t      reg_req,
   output emu_pkg::reg_rsp_t      reg_rsp,
   output logic [`EMU_DATA_W-1:0] out_tdata,
   output logic                   out_tvalid,
   input  logic                   out_tready,
   output logic                   enable,
   output emu_pkg::emu_cfg_t      cfg
);
   import emu_pkg::*;

   fifo_sel_t              active;
   fifo_sel_t              on_deck;
   logic [1:0]             load_strobe;
   logic [`EMU_DATA_W-1:0] load_data;
   logic [1:0]             clear;
   logic [`EMU_LEN_W-1:0]  len0;
   logic [`EMU_LEN_W-1:0]  len1;
   logic [1:0]             pop;
   logic [1:0]             empty;
   logic [`EMU_DATA_W-1:0] head [2];

   // Push register per FIFO
   logic [1:0]             push;
   logic [`EMU_DATA_W-1:0] push_data [2];

   // Frame generator runs whenever a FIFO streams
   assign enable = (active != SEL_NONE);

   emu_regs emu_regs_i (
      .clk         (clk),
      .resetn      (resetn),
      .req         (reg_req),
      .rsp         (reg_rsp),
      .active      (active),
      .load_strobe (load_strobe),
      .load_data   (load_data),
      .clear       (clear),
      .on_deck     (on_deck),
      .len0        (len0),
      .len1        (len1),
      .cfg         (cfg)
   );

   //==================================================
   // Write-back mux
   //==================================================
   // Load or recirculation, never both for the same FIFO
   always_ff @(posedge clk) begin
      for (int i = 0; i < 2; i++) begin
         if (!resetn) push[i] <= 1'b0;
         else push[i] <= load_strobe[i] | pop[i];
      end
   end

   // Popped word goes back in one cycle after it left
   always_ff @(posedge clk) begin
      for (int i = 0; i < 2; i++) begin
         push_data[i] <= load_strobe[i] ? load_data : head[i];
      end
   end

   for (genvar i = 0; i < 2; i++) begin : g_fifo
      pattern_fifo #(.DEPTH(`EMU_FIFO_DEPTH)) pattern_fifo_i (
         .clk       (clk),
         .resetn    (resetn),
         .clear     (clear[i]),
         .push      (push[i]),
         .push_data (push_data[i]),
         .pop       (pop[i]),
         .head      (head[i]),
         .empty     (empty[i])
      );
   end

   pattern_stream pattern_stream_i (
      .clk        (clk),
      .resetn     (resetn),
      .on_deck    (on_deck),
      .len0       (len0),
      .len1       (len1),
      .head0      (head[0]),
      .head1      (head[1]),
      .empty0     (empty[0]),
      .empty1     (empty[1]),
      .pop        (pop),
      .active     (active),
      .out_tdata  (out_tdata),
      .out_tvalid (out_tvalid),
      .out_tready (out_tready)
   );

endmodule

//--- testbench/tb_sensor_emu_ctl.sv
// Pattern controller testbench with clock, reset, register stimulus, reference model and checks
`timescale 1ns/1ps
`include "emu_consts.svh"

module tb_sensor_emu_ctl;
   import emu_pkg::*;

   // About 40 register accesses and 30 beats at 75% ready fit well inside this
   localparam int TIMEOUT_CYCLES = 4000;

   logic                   clk;
   logic                   resetn = 1'b0;
   reg_req_t               reg_req = '0;
   reg_rsp_t               reg_rsp;
   logic [`EMU_DATA_W-1:0] out_tdata;
   logic                   out_tvalid;
   logic                   out_tready = 1'b1;
   logic                   enable;
   emu_cfg_t               cfg;

   //==================================================
   // Reference model state
   //==================================================
   logic [`EMU_DATA_W-1:0] model_list [2][`EMU_FIFO_DEPTH];
   int        model_len [2] = '{0, 0};
   fifo_sel_t model_deck = SEL_NONE;
   fifo_sel_t model_cur  = SEL_NONE;
   int        pass_beat  = 0;
   int        pass_len   = 0;
   int        beats_seen [2] = '{0, 0};

   // Run bookkeeping
   string current_test = "reset";
   int    error_count = 0;
   int    errors_at_start = 0;
   int    tests_run = 0;
   int    tests_clean = 0;
   int    cycle_count = 0;
   logic  ready_random = 1'b0;

   sensor_emu_ctl sensor_emu_ctl_i (
      .clk        (clk),
      .resetn     (resetn),
      .reg_req    (reg_req),
      .reg_rsp    (reg_rsp),
      .out_tdata  (out_tdata),
      .out_tvalid (out_tvalid),
      .out_tready (out_tready),
      .enable     (enable),
      .cfg        (cfg)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) cycle_count <= cycle_count + 1;

   initial begin : watchdog
      wait (cycle_count >= TIMEOUT_CYCLES);
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Testbench failed");
      $finish;
   end

   // Random sink back-pressure with one draw per cycle
   always @(negedge clk) begin
      if (ready_random) out_tready = ($urandom % 4) != 0;
      else out_tready = 1'b1;
   end

   //==================================================
   // Helpers
   //==================================================
   function automatic int sel_index(input fifo_sel_t sel);
      return (sel == SEL_F1) ? 1 : 0;
   endfunction

   // Beat k of a pass is list[k mod length]
   function automatic logic [`EMU_DATA_W-1:0] expected_word(input int fifo, input int k);
      if (model_len[fifo] == 0) return '0;
      return model_list[fifo][k % model_len[fifo]];
   endfunction

   // START only selects a FIFO that holds a pattern
   function automatic fifo_sel_t deck_after_start(input logic [`EMU_DATA_W-1:0] value);
      case (value)
         0: return SEL_NONE;
         1: return (model_len[0] != 0) ? SEL_F0 : model_deck;
         2: return (model_len[1] != 0) ? SEL_F1 : model_deck;
         default: return model_deck;
      endcase
   endfunction

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         error_count++;
         $display("ERROR %s (%s): expected %08h, actual %08h", current_test, what,
                  expected, actual);
      end
   endtask

   task automatic reg_access(input logic write, input int index, input logic [31:0] data,
                             output logic [31:0] rdata, output logic err);
      @(negedge clk);
      reg_req.write = write;
      reg_req.read  = !write;
      reg_req.index = `EMU_INDEX_W'(index);
      reg_req.data  = data;
      @(negedge clk);
      reg_req = '0;
      // Response is due exactly one cycle after the strobe
      if (!reg_rsp.valid) begin
         error_count++;
         $display("%s: no register response one cycle after access to index %0d",
                  current_test, index);
      end
      rdata = reg_rsp.data;
      err   = reg_rsp.err;
   endtask

   task automatic reg_write(input int index, input logic [31:0] data);
      logic [31:0] rdata;
      logic        err;
      reg_access(1'b1, index, data, rdata, err);
      check_value("write decode error", 32'd0, 32'(err));
   endtask

   task automatic reg_read_check(input int index, input logic [31:0] expected, input string what);
      logic [31:0] rdata;
      logic        err;
      reg_access(1'b0, index, 32'd0, rdata, err);
      check_value("read decode error", 32'd0, 32'(err));
      check_value(what, expected, rdata);
   endtask

   // Taken loads extend the model list
   task automatic load_word(input int fifo, input logic [31:0] word, input logic taken);
      reg_write(`EMU_REG_LOAD_F0 + fifo, word);
      if (taken) begin
         model_list[fifo][model_len[fifo]] = word;
         model_len[fifo]++;
      end
   endtask

   task automatic test_begin(input string name);
      current_test    = name;
      errors_at_start = error_count;
   endtask

   task automatic test_end();
      tests_run++;
      if (error_count == errors_at_start) begin
         tests_clean++;
         $display("Test %s: ok", current_test);
      end else begin
         $display("Test %s: %0d errors", current_test, error_count - errors_at_start);
      end
   endtask

   //==================================================
   // Stream monitor and compare
   //==================================================
   always @(posedge clk) begin
      if (resetn) begin
         if (model_cur == SEL_NONE) begin
            if (out_tvalid && out_tready) begin
               error_count++;
               $display("%s: stream handshake while no FIFO should be active", current_test);
            end
            // Idle engine picks up the deck one cycle after it changes
            if (model_deck != SEL_NONE) begin
               model_cur = model_deck;
               pass_beat = 0;
               pass_len  = model_len[sel_index(model_deck)];
            end
         end else if (out_tvalid && out_tready) begin
            check_value("stream beat", expected_word(sel_index(model_cur), pass_beat), out_tdata);
            beats_seen[sel_index(model_cur)]++;
            pass_beat++;
            // Deck is re-read at the end of a pass
            if (pass_beat >= pass_len) begin
               pass_beat = 0;
               model_cur = model_deck;
               if (model_deck != SEL_NONE) pass_len = model_len[sel_index(model_deck)];
            end
         end
         // START write takes effect at this edge
         if (reg_req.write && (reg_req.index == `EMU_REG_START))
            model_deck = deck_after_start(reg_req.data);
      end
   end

   //==================================================
   // Test sequence
   //==================================================
   initial begin : main
      logic [31:0] rdata;
      logic        err;
      void'($urandom(8));
      repeat (3) @(posedge clk);
      @(negedge clk);
      resetn = 1'b1;

      test_begin("reset_defaults");
      check_value("out_tvalid", 32'd0, 32'(out_tvalid));
      check_value("enable", 32'd0, 32'(enable));
      reg_read_check(`EMU_REG_VERSION, 32'd1, "version");
      reg_read_check(`EMU_REG_CYCLES, 32'h0001_0000, "cycles");
      reg_read_check(`EMU_REG_IDLE, 32'h0000_AABB, "idle bytes");
      reg_read_check(`EMU_REG_LOAD_F0, 32'd0, "length f0");
      reg_read_check(`EMU_REG_LOAD_F1, 32'd0, "length f1");
      reg_read_check(`EMU_REG_START, 32'd0, "start");
      test_end();

      test_begin("config_decode");
      reg_write(`EMU_REG_CYCLES, 32'h0000_2710);
      reg_read_check(`EMU_REG_CYCLES, 32'h0000_2710, "cycles written");
      check_value("cfg cycles", 32'h0000_2710, cfg.cycles);
      // Zero cycles per frame is not a valid setting
      reg_write(`EMU_REG_CYCLES, 32'd0);
      reg_read_check(`EMU_REG_CYCLES, 32'h0000_2710, "cycles after zero");
      reg_write(`EMU_REG_IDLE, 32'h0000_C33C);
      check_value("cfg idle0", 32'h0000_00C3, 32'(cfg.idle0));
      check_value("cfg idle1", 32'h0000_003C, 32'(cfg.idle1));
      reg_read_check(`EMU_REG_IDLE, 32'h0000_C33C, "idle bytes");
      reg_access(1'b0, 9, 32'd0, rdata, err);
      check_value("read index 9 error", 32'd1, 32'(err));
      reg_access(1'b1, 9, 32'h1234_5678, rdata, err);
      check_value("write index 9 error", 32'd1, 32'(err));
      test_end();

      test_begin("looping_stream");
      ready_random = 1'b1;
      for (int i = 0; i < 5; i++) load_word(0, $urandom, 1'b1);
      reg_read_check(`EMU_REG_LOAD_F0, 32'd5, "length f0");
      reg_write(`EMU_REG_START, 32'd1);
      while (!enable) @(negedge clk);
      reg_read_check(`EMU_REG_START, 32'd1, "start");
      while (beats_seen[0] < 15) @(negedge clk);
      test_end();

      test_begin("switch_fifo");
      for (int i = 0; i < 3; i++) load_word(1, $urandom, 1'b1);
      reg_read_check(`EMU_REG_LOAD_F1, 32'd3, "length f1");
      // F0 is streaming and refuses this load
      load_word(0, $urandom, 1'b0);
      reg_read_check(`EMU_REG_LOAD_F0, 32'd5, "length f0 after refused load");
      reg_write(`EMU_REG_START, 32'd2);
      while (beats_seen[1] < 6) @(negedge clk);
      reg_read_check(`EMU_REG_START, 32'd2, "start");
      test_end();

      test_begin("stop_clear");
      reg_write(`EMU_REG_START, 32'd0);
      while (enable) @(negedge clk);
      check_value("out_tvalid after stop", 32'd0, 32'(out_tvalid));
      check_value("model active after stop", 32'(SEL_NONE), 32'(model_cur));
      reg_write(`EMU_REG_FIFO_CTL, 32'd1 << `EMU_BIT_CLR_F0);
      model_len[0] = 0;
      reg_read_check(`EMU_REG_LOAD_F0, 32'd0, "length f0 after clear");
      reg_write(`EMU_REG_START, 32'd1);
      reg_read_check(`EMU_REG_START, 32'd0, "start on empty f0");
      check_value("enable after refused start", 32'd0, 32'(enable));
      test_end();

      ready_random = 1'b0;
      $display("Summary: %0d of %0d tests clean, %0d beats checked, %0d errors",
               tests_clean, tests_run, beats_seen[0] + beats_seen[1], error_count);
      if (error_count == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule
